// ==== frontend_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module frontend_checker
(
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         hs_kick,
    input  logic                                         hs_done,
    input  logic                                         out_valid,
    input  logic [nabp_pkg::k_angle_length-1:0]          out_angle,
    input  logic [nabp_pkg::k_s_length-1:0]              out_s,
    input  logic signed [nabp_pkg::k_filtered_width-1:0] out_value,
    output int                                           order_errors,
    output int                                           value_errors,
    output int                                           done_errors,
    output int                                           reset_errors,
    output int                                           runs_completed
);

    import nabp_pkg::*;

    localparam int strobes_per_run = k_no_of_angles * k_line_size;

    logic [k_sample_width-1:0] ref_mem [0:strobes_per_run-1];

    int order_count = 0;
    int value_count = 0;
    int done_count = 0;
    int reset_count = 0;
    int run_count = 0;

    bit kicked = 1'b0;
    bit run_active = 1'b0;
    bit done_prev = 1'b0;
    int strobe_idx = 0;

    assign order_errors   = order_count;
    assign value_errors   = value_count;
    assign done_errors    = done_count;
    assign reset_errors   = reset_count;
    assign runs_completed = run_count;

    initial
    begin
        $readmemh(k_sinogram_file, ref_mem);
    end

    // kernel 2x[s] - x[s-1] - x[s-2] with zeros before the line start
    function automatic int expected_value(input int line_idx, input int pos);
        int cur;
        int prev_1;
        int prev_2;
        cur    = int'(ref_mem[line_idx * k_line_size + pos]);
        prev_1 = (pos >= 1) ? int'(ref_mem[line_idx * k_line_size + pos - 1]) : 0;
        prev_2 = (pos >= 2) ? int'(ref_mem[line_idx * k_line_size + pos - 2]) : 0;
        return 2 * cur - prev_1 - prev_2;
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk)
    begin
        int exp_angle;
        int exp_pos;
        int expected;
        int actual;
        actual = int'(out_value);
        if (reset_n)
        begin
            if (out_valid !== 1'b0 || hs_done !== 1'b0)
            begin
                reset_count++;
                $display("out_valid or hs_done went high while reset was held");
            end
        end
        else
        begin
            if (!kicked && (out_valid !== 1'b0 || hs_done !== 1'b0))
            begin
                reset_count++;
                $display("out_valid or hs_done went high before the first kick");
            end
            // kicks inside a run are ignored by the DUT too
            if (hs_kick && !run_active)
            begin
                kicked     = 1'b1;
                run_active = 1'b1;
                strobe_idx = 0;
            end
            if (kicked && out_valid)
            begin
                if (!run_active)
                begin
                    order_count++;
                    $display("out_valid strobe seen outside of a run");
                end
                else if (strobe_idx >= strobes_per_run)
                begin
                    order_count++;
                    $display("more strobes than expected in one run");
                end
                else
                begin
                    exp_angle = (strobe_idx / k_line_size) * k_angle_step;
                    exp_pos   = strobe_idx % k_line_size;
                    expected  = expected_value(strobe_idx / k_line_size, exp_pos);
                    if (int'(out_angle) != exp_angle)
                    begin
                        order_count++;
                        $display("error order_angle: expected %0d, actual %0d",
                                 exp_angle, out_angle);
                    end
                    if (int'(out_s) != exp_pos)
                    begin
                        order_count++;
                        $display("error order_position: expected %0d, actual %0d",
                                 exp_pos, out_s);
                    end
                    if (actual != expected)
                    begin
                        value_count++;
                        $display("error filter_value: expected %0d, actual %0d",
                                 expected, actual);
                    end
                end
                strobe_idx++;
            end
            // the cycle after done carries the last strobe of the run
            if (done_prev)
            begin
                if (!out_valid || strobe_idx != strobes_per_run)
                begin
                    done_count++;
                    $display("run did not end with its last strobe right after hs_done");
                end
                run_active = 1'b0;
                run_count++;
            end
            // a repeated or stretched done lands after the run has closed
            if (hs_done && !run_active)
            begin
                done_count++;
                $display("hs_done pulsed outside of a run");
            end
            done_prev = hs_done && run_active;
        end
    end

endmodule

`default_nettype wire

// ==== line_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_sequencer
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            fr_next_angle_ack,
    output logic                            fr_next_angle,
    output logic [nabp_pkg::k_s_length-1:0] s_val,
    output logic                            sample_valid
);

    import nabp_pkg::*;

    // high while a line is being issued
    logic streaming;
    logic last_pos;

    assign last_pos = (s_val == k_s_length'(k_line_size - 1));

    // between lines the sequencer keeps asking for the next angle
    assign fr_next_angle = !streaming;
    assign sample_valid  = streaming;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            streaming <= 1'b0;
        else if (!streaming)
        begin
            if (fr_next_angle_ack)
                streaming <= 1'b1;
        end
        else if (last_pos)
            streaming <= 1'b0;
    end

    // position counter, restarted on every acknowledge
    always_ff @(posedge clk)
    begin
        if (reset_n)
            s_val <= '0;
        else if (!streaming)
        begin
            if (fr_next_angle_ack)
                s_val <= '0;
        end
        else if (!last_pos)
            s_val <= s_val + 1'b1;
    end

endmodule

`default_nettype wire

// ==== list.f ====
nabp_pkg.sv
sinogram_addresser.sv
line_sequencer.sv
sinogram_ram.sv
ramp_filter.sv
nabp_frontend.sv
frontend_checker.sv
tb_nabp_frontend.sv

// ==== nabp_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module nabp_frontend
(
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         hs_kick,
    output logic                                         hs_done,
    output logic                                         out_valid,
    output logic [nabp_pkg::k_angle_length-1:0]          out_angle,
    output logic [nabp_pkg::k_s_length-1:0]              out_s,
    output logic signed [nabp_pkg::k_filtered_width-1:0] out_value
);

    import nabp_pkg::*;

    logic                        fr_next_angle;
    logic                        fr_next_angle_ack;
    logic [k_angle_length-1:0]   fr_angle;
    logic [k_s_length-1:0]       s_val;
    logic                        sample_valid;
    logic [k_sg_addr_length-1:0] sg_addr;

    // memory stage outputs
    logic [k_sample_width-1:0]   rd_data;
    logic                        rd_valid;
    logic [k_angle_length-1:0]   rd_angle;
    logic [k_s_length-1:0]       rd_s;

    // angle sweep and line base address
    sinogram_addresser u_addresser
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_kick           (hs_kick),
        .fr_s_val          (s_val),
        .fr_next_angle     (fr_next_angle),
        .hs_done           (hs_done),
        .fr_angle          (fr_angle),
        .fr_has_next_angle (),
        .fr_next_angle_ack (fr_next_angle_ack),
        .sg_addr           (sg_addr)
    );

    line_sequencer u_sequencer
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr_next_angle     (fr_next_angle),
        .s_val             (s_val),
        .sample_valid      (sample_valid)
    );

    // one cycle read latency, tags delayed alongside
    sinogram_ram u_ram
    (
        .clk          (clk),
        .sg_addr      (sg_addr),
        .sample_valid (sample_valid),
        .angle        (fr_angle),
        .s_val        (s_val),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .rd_angle     (rd_angle),
        .rd_s         (rd_s)
    );

    ramp_filter u_filter
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_angle  (rd_angle),
        .rd_s      (rd_s),
        .out_valid (out_valid),
        .out_angle (out_angle),
        .out_s     (out_s),
        .out_value (out_value)
    );

endmodule

`default_nettype wire

// ==== nabp_pkg.sv ====
`default_nettype none

package nabp_pkg;

    // angles are whole degrees held in one byte
    localparam int k_angle_length = 8;

    // sweep runs from 0 up to but not including the span
    localparam int k_angle_step = 30;
    localparam int k_angle_span = 180;

    // one projection line per angle step
    localparam int k_no_of_angles = 6;

    // samples along one projection line
    localparam int k_line_size = 8;

    // position within a line, 0 to k_line_size-1
    localparam int k_s_length = 3;

    // flat index over all lines, k_no_of_angles * k_line_size words
    localparam int k_sg_addr_length = 6;

    // raw sinogram samples are unsigned
    localparam int k_sample_width = 12;

    // 2x - a - b of 12 bit samples spans -8190 to 8190
    localparam int k_filtered_width = 14;

    // memory image for the sinogram RAM
    localparam string k_sinogram_file = "sinogram.hex";

endpackage

`default_nettype wire

// ==== ramp_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ramp_filter
(
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic [nabp_pkg::k_sample_width-1:0]         rd_data,
    input  logic                                        rd_valid,
    input  logic [nabp_pkg::k_angle_length-1:0]         rd_angle,
    input  logic [nabp_pkg::k_s_length-1:0]             rd_s,
    output logic                                        out_valid,
    output logic [nabp_pkg::k_angle_length-1:0]         out_angle,
    output logic [nabp_pkg::k_s_length-1:0]             out_s,
    output logic signed [nabp_pkg::k_filtered_width-1:0] out_value
);

    import nabp_pkg::*;

    // previous sample and the one before it
    logic [k_sample_width-1:0] hist_1;
    logic [k_sample_width-1:0] hist_2;

    logic                      first_sample;
    logic [k_sample_width-1:0] prev_1;
    logic [k_sample_width-1:0] prev_2;

    logic signed [k_filtered_width-1:0] cur_ext;
    logic signed [k_filtered_width-1:0] prev_1_ext;
    logic signed [k_filtered_width-1:0] prev_2_ext;
    logic signed [k_filtered_width-1:0] result;

    // samples before position 0 count as zero
    assign first_sample = (rd_s == '0);
    assign prev_1 = first_sample ? '0 : hist_1;
    assign prev_2 = first_sample ? '0 : hist_2;

    // zero extend the unsigned samples into the signed domain
    assign cur_ext    = $signed({{(k_filtered_width-k_sample_width){1'b0}}, rd_data});
    assign prev_1_ext = $signed({{(k_filtered_width-k_sample_width){1'b0}}, prev_1});
    assign prev_2_ext = $signed({{(k_filtered_width-k_sample_width){1'b0}}, prev_2});

    // sharpening kernel 2x[s] - x[s-1] - x[s-2]
    assign result = (cur_ext <<< 1) - prev_1_ext - prev_2_ext;

    // shift history, starting clean at each line
    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            hist_1 <= rd_data;
            hist_2 <= prev_1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            out_valid <= 1'b0;
        else
            out_valid <= rd_valid;
    end

    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            out_angle <= rd_angle;
            out_s     <= rd_s;
            out_value <= result;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
top=tb_nabp_frontend

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f --top-module "$top" -o sim_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_frontend > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$log"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1

// ==== sinogram.hex ====
// one 12 bit raw sample per line, hex
// six projection lines of eight samples, angle 0 first
100
200
300
400
500
600
700
800
0FF
0FF
0FF
0FF
0FF
0FF
0FF
0FF
FFF
000
FFF
000
FFF
000
FFF
000
001
010
100
800
100
010
001
000
3A7
5C2
1E9
7B4
2D0
6F1
0A8
4E3
800
7FF
000
FFF
123
ABC
456
DEF

// ==== sinogram_addresser.sv ====
`timescale 1ns/1ns
`default_nettype none

module sinogram_addresser
(
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 hs_kick,
    input  logic [nabp_pkg::k_s_length-1:0]      fr_s_val,
    input  logic                                 fr_next_angle,
    output logic                                 hs_done,
    output logic [nabp_pkg::k_angle_length-1:0]  fr_angle,
    output logic                                 fr_has_next_angle,
    output logic                                 fr_next_angle_ack,
    output logic [nabp_pkg::k_sg_addr_length-1:0] sg_addr
);

    import nabp_pkg::*;

    // 0 is ready, 1 is work
    logic work_state;
    logic next_work_state;

    // set by the first acknowledge so angle 0 keeps its own line
    logic initialised;

    logic [k_sg_addr_length-1:0] sg_base;

    assign fr_has_next_angle =
        (fr_angle < k_angle_length'(k_angle_span - k_angle_step));

    // done only counts while working, so it cannot repeat in ready
    assign hs_done = work_state && fr_next_angle && !fr_has_next_angle;

    assign fr_next_angle_ack = work_state && fr_next_angle && fr_has_next_angle;

    // line base plus position within the line
    assign sg_addr = sg_base + k_sg_addr_length'(fr_s_val);

    always_comb
    begin
        next_work_state = work_state;
        if (!work_state)
        begin
            if (hs_kick)
                next_work_state = 1'b1;
        end
        else
        begin
            if (hs_done)
                next_work_state = 1'b0;
        end
    end

    // reset_n is active high
    always_ff @(posedge clk)
    begin
        if (reset_n)
            work_state <= 1'b0;
        else
            work_state <= next_work_state;
    end

    // angle and base restart from zero whenever the engine is idle
    always_ff @(posedge clk)
    begin
        if (reset_n || !work_state)
        begin
            initialised <= 1'b0;
            fr_angle    <= '0;
            sg_base     <= '0;
        end
        else if (fr_next_angle_ack)
        begin
            if (!initialised)
                initialised <= 1'b1;
            else
            begin
                fr_angle <= fr_angle + k_angle_length'(k_angle_step);
                sg_base  <= sg_base + k_sg_addr_length'(k_line_size);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sinogram_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module sinogram_ram
(
    input  logic                                  clk,
    input  logic [nabp_pkg::k_sg_addr_length-1:0] sg_addr,
    input  logic                                  sample_valid,
    input  logic [nabp_pkg::k_angle_length-1:0]   angle,
    input  logic [nabp_pkg::k_s_length-1:0]       s_val,
    output logic [nabp_pkg::k_sample_width-1:0]   rd_data,
    output logic                                  rd_valid,
    output logic [nabp_pkg::k_angle_length-1:0]   rd_angle,
    output logic [nabp_pkg::k_s_length-1:0]       rd_s
);

    import nabp_pkg::*;

    logic [k_sample_width-1:0] mem [0:k_no_of_angles*k_line_size-1];

    initial
    begin
        $readmemh(k_sinogram_file, mem);
    end

    // tags ride along so they line up with the read word
    always_ff @(posedge clk)
    begin
        rd_data  <= mem[sg_addr];
        rd_valid <= sample_valid;
        rd_angle <= angle;
        rd_s     <= s_val;
    end

endmodule

`default_nettype wire

// ==== tb_nabp_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_nabp_frontend;

    import nabp_pkg::*;

    localparam int          n_runs       = 3;
    localparam int          drive_delay  = 2;
    localparam int          max_gap      = 10;
    localparam logic [31:0] lcg_seed     = 32'h7ab57ed5;

    // kick, one cycle per sample, one per request, plus pipeline drain
    localparam int run_cycles     = k_no_of_angles * (k_line_size + 1) + 3;
    localparam int timeout_cycles = 2 * n_runs * (run_cycles + max_gap);

    logic                               clk;
    logic                               reset_n;
    logic                               hs_kick;
    logic                               hs_done;
    logic                               out_valid;
    logic [k_angle_length-1:0]          out_angle;
    logic [k_s_length-1:0]              out_s;
    logic signed [k_filtered_width-1:0] out_value;

    int order_errors;
    int value_errors;
    int done_errors;
    int reset_errors;
    int runs_completed;
    int run_errors;
    int cycle_count;

    nabp_frontend DUT
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .hs_kick   (hs_kick),
        .hs_done   (hs_done),
        .out_valid (out_valid),
        .out_angle (out_angle),
        .out_s     (out_s),
        .out_value (out_value)
    );

    frontend_checker u_checker
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .hs_kick        (hs_kick),
        .hs_done        (hs_done),
        .out_valid      (out_valid),
        .out_angle      (out_angle),
        .out_s          (out_s),
        .out_value      (out_value),
        .order_errors   (order_errors),
        .value_errors   (value_errors),
        .done_errors    (done_errors),
        .reset_errors   (reset_errors),
        .runs_completed (runs_completed)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_errors();
        return order_errors + value_errors + done_errors + reset_errors + run_errors;
    endfunction

    task automatic print_counts();
        $display("errors: order %0d, value %0d, done %0d, reset %0d, runs %0d",
                 order_errors, value_errors, done_errors, reset_errors, run_errors);
    endtask

    // one cycle kick, driven just after the edge
    task automatic pulse_kick();
        @(posedge clk);
        #drive_delay;
        hs_kick = 1'b1;
        @(posedge clk);
        #drive_delay;
        hs_kick = 1'b0;
    endtask

    task automatic wait_for_done();
        @(negedge clk);
        while (!hs_done)
            @(negedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        print_counts();
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        logic [31:0] lcg_state;
        int gap;
        // reset_n is active high here
        reset_n    = 1'b1;
        hs_kick    = 1'b0;
        run_errors = 0;
        lcg_state  = lcg_seed;
        repeat (2) @(posedge clk);
        #drive_delay;
        reset_n = 1'b0;
        for (int run = 0; run < n_runs; run++)
        begin
            pulse_kick();
            // second run gets a stray kick while busy
            if (run == 1)
            begin
                repeat (3) @(posedge clk);
                pulse_kick();
            end
            wait_for_done();
            lcg_state = lcg_next(lcg_state);
            gap = 3 + int'(lcg_state[18:16]);
            repeat (gap) @(posedge clk);
        end
        if (runs_completed != n_runs)
        begin
            run_errors++;
            $display("only %0d of %0d runs completed", runs_completed, n_runs);
        end
        print_counts();
        if (total_errors() == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
